//--- Makefile
# Verilator flow for the ramio testbench

TOP := ramio_tb

.PHONY: all lint sim clean

all: sim

# lint the design top on its own
lint:
	verilator --lint-only --timing -f src.f --top-module ramio

# build, run, then decide pass or fail from the log
sim:
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q 'All tests passed!' sim.log

clean:
	rm -rf obj_dir sim.log

//--- logic/access_decode.sv
`timescale 1ns/1ps
`include "ramio_settings.svh"

module access_decode (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        enable,
  input  cpu_bus_pkg::write_type_t    write_type,
  input  cpu_bus_pkg::read_type_t     read_type,
  input  logic [`CPU_ADDR_BITS-1:0]   address,
  input  logic [`CPU_DATA_BITS-1:0]   data_in,
  input  logic                        op_ready,
  output logic                        busy,
  output cpu_bus_pkg::mem_op_t        op,
  output logic                        op_valid
);

  cpu_bus_pkg::mem_op_t next_op;
  logic [`BR_DATA_BITS/8-1:0] lane_mask;
  logic [`BR_DATA_BITS-1:0] wide_data;
  logic accept;

  // slot full and the cache not taking it this cycle
  assign busy = op_valid && !op_ready;
  assign accept = enable && !busy;

  assign wide_data = `BR_DATA_BITS'(data_in);

  always_comb begin
    case (write_type)
      cpu_bus_pkg::WR_BYTE: lane_mask = 8'h01;
      cpu_bus_pkg::WR_HALF: lane_mask = 8'h03;
      cpu_bus_pkg::WR_WORD: lane_mask = 8'h0f;
      default:              lane_mask = 8'h00;  // read
    endcase
  end

  always_comb begin
    next_op = '0;
    next_op.line_addr = address[`RAM_ADDR_BITS-1:3];
    next_op.offset = address[2:0];
    next_op.is_write = (write_type != cpu_bus_pkg::WR_NONE);
    next_op.byte_mask = lane_mask << address[2:0];
    next_op.wr_data = wide_data << {address[2:0], 3'b000};  // move into lane
    next_op.read_type = read_type;
  end

  // one-entry output slot
  always_ff @(posedge clk) begin
    if (reset) begin
      op_valid <= 1'b0;
    end else if (accept) begin
      op_valid <= 1'b1;
    end else if (op_ready) begin
      op_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op <= next_op;
    end
  end

endmodule

//--- logic/burst_ram_pkg.sv
`include "ramio_settings.svh"

// ---------------------------------------------------------------------------
// burst side of ramio: line data and controller commands
// ---------------------------------------------------------------------------
package burst_ram_pkg;

  typedef logic [`BR_DATA_BITS-1:0] line_t;

  typedef enum logic {
    BR_READ  = 1'b0,
    BR_WRITE = 1'b1
  } br_cmd_kind_t;

  typedef struct packed {
    br_cmd_kind_t                cmd;
    logic [`RAM_ADDR_BITS-1:0]   addr;       // byte address, line aligned
    line_t                       wr_data;
    logic [`BR_DATA_BITS/8-1:0]  data_mask;  // 0 writes the byte
  } br_cmd_t;

  // hit line on its way to the load aligner
  typedef struct packed {
    line_t                    data;
    logic [2:0]               offset;
    cpu_bus_pkg::read_type_t  read_type;
  } load_rsp_t;

endpackage

//--- logic/cpu_bus_pkg.sv
`include "ramio_settings.svh"

// ---------------------------------------------------------------------------
// cpu side of ramio: access kinds and the decoded operation
// ---------------------------------------------------------------------------
package cpu_bus_pkg;

  typedef enum logic [1:0] {
    WR_NONE = 2'd0,
    WR_BYTE = 2'd1,
    WR_HALF = 2'd2,
    WR_WORD = 2'd3
  } write_type_t;

  // bit 2 marks the zero-extended loads
  typedef enum logic [2:0] {
    RD_NONE   = 3'd0,
    RD_BYTE   = 3'd1,
    RD_HALF   = 3'd2,
    RD_WORD   = 3'd3,
    RD_BYTE_U = 3'd5,
    RD_HALF_U = 3'd6
  } read_type_t;

  typedef struct packed {
    logic [`LINE_ADDR_BITS-1:0]  line_addr;  // address above the line offset
    logic                        is_write;
    logic [`BR_DATA_BITS/8-1:0]  byte_mask;  // lanes touched by a write
    logic [`BR_DATA_BITS-1:0]    wr_data;    // already in lane position
    logic [2:0]                  offset;
    read_type_t                  read_type;
  } mem_op_t;

endpackage

//--- logic/line_cache.sv
`timescale 1ns/1ps
`include "ramio_settings.svh"

module line_cache (
  input  logic                      clk,
  input  logic                      reset,
  input  cpu_bus_pkg::mem_op_t      op,
  input  logic                      op_valid,
  output logic                      op_ready,
  input  logic                      init_calib,
  output burst_ram_pkg::br_cmd_t    br_req,
  output logic                      br_cmd_en,
  input  burst_ram_pkg::line_t      br_rd_data,
  input  logic                      br_rd_data_valid,
  output burst_ram_pkg::load_rsp_t  rsp,
  output logic                      rsp_valid
);

  localparam int LINES = 1 << `LINE_INDEX_BITS;
  localparam int TAG_BITS = `LINE_ADDR_BITS - `LINE_INDEX_BITS;
  localparam int GAP_BITS = $clog2(`BR_WRITE_GAP + 2);
  localparam int LANES = `BR_DATA_BITS / 8;

  typedef enum logic [2:0] {
    S_LOOKUP,     // hit check on the held operation
    S_WRITEBACK,  // dirty victim goes out
    S_GAP,        // idle time after the write command
    S_READ,       // request the missing line
    S_FILL        // wait for read data
  } state_t;

  state_t state;
  cpu_bus_pkg::mem_op_t cur_op;
  logic cur_valid;
  logic [GAP_BITS-1:0] gap_cnt;

  // ---------------------------------------------------------------------------
  // line storage
  // ---------------------------------------------------------------------------
  logic [TAG_BITS-1:0] tag_mem [LINES];
  burst_ram_pkg::line_t data_mem [LINES];
  logic [LINES-1:0] line_valid;
  logic [LINES-1:0] line_dirty;

  logic [`LINE_INDEX_BITS-1:0] idx;
  logic [TAG_BITS-1:0] tag;
  logic hit;
  burst_ram_pkg::line_t merged;
  logic [`RAM_ADDR_BITS-1:0] victim_addr;
  logic [`RAM_ADDR_BITS-1:0] fill_addr;

  assign idx = cur_op.line_addr[`LINE_INDEX_BITS-1:0];
  assign tag = cur_op.line_addr[`LINE_ADDR_BITS-1:`LINE_INDEX_BITS];

  assign hit = cur_valid && (state == S_LOOKUP) && line_valid[idx] && (tag_mem[idx] == tag);

  // stage frees up on the same edge a hit completes
  assign op_ready = !cur_valid || hit;

  assign victim_addr = {tag_mem[idx], idx, 3'b000};
  assign fill_addr = {cur_op.line_addr, 3'b000};

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      merged[i*8 +: 8] = cur_op.byte_mask[i] ? cur_op.wr_data[i*8 +: 8]
                                             : data_mem[idx][i*8 +: 8];
    end
  end

  // ---------------------------------------------------------------------------
  // control and miss sequencer
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_LOOKUP;
      cur_valid <= 1'b0;
      line_valid <= '0;
      line_dirty <= '0;
      gap_cnt <= '0;
      br_cmd_en <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      br_cmd_en <= 1'b0;  // single-cycle strobes
      rsp_valid <= 1'b0;

      if (op_valid && op_ready) begin
        cur_valid <= 1'b1;
      end else if (hit) begin
        cur_valid <= 1'b0;
      end

      case (state)
        S_LOOKUP: begin
          if (hit) begin
            if (cur_op.is_write) begin
              line_dirty[idx] <= 1'b1;
            end else begin
              rsp_valid <= 1'b1;
            end
          end else if (cur_valid) begin
            if (line_valid[idx] && line_dirty[idx]) begin
              state <= S_WRITEBACK;
            end else begin
              state <= S_READ;
            end
          end
        end
        S_WRITEBACK: begin
          if (init_calib) begin
            br_cmd_en <= 1'b1;
            line_dirty[idx] <= 1'b0;
            gap_cnt <= GAP_BITS'(`BR_WRITE_GAP);
            state <= S_GAP;
          end
        end
        S_GAP: begin
          if (gap_cnt <= GAP_BITS'(1)) begin
            state <= S_READ;
          end else begin
            gap_cnt <= gap_cnt - 1'b1;
          end
        end
        S_READ: begin
          if (init_calib) begin
            br_cmd_en <= 1'b1;
            state <= S_FILL;
          end
        end
        S_FILL: begin
          if (br_rd_data_valid) begin
            line_valid[idx] <= 1'b1;
            state <= S_LOOKUP;  // replay now hits
          end
        end
        default: state <= S_LOOKUP;
      endcase
    end
  end

  // ---------------------------------------------------------------------------
  // data path
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (op_valid && op_ready) begin
      cur_op <= op;
    end

    if (hit && cur_op.is_write) begin
      data_mem[idx] <= merged;
    end
    if (state == S_FILL && br_rd_data_valid) begin
      data_mem[idx] <= br_rd_data;
      tag_mem[idx] <= tag;
    end

    if (hit && !cur_op.is_write) begin
      rsp <= '{data: data_mem[idx], offset: cur_op.offset, read_type: cur_op.read_type};
    end

    // whole line always so the mask stays zero
    if (state == S_WRITEBACK) begin
      br_req <= '{cmd: burst_ram_pkg::BR_WRITE, addr: victim_addr,
                  wr_data: data_mem[idx], data_mask: '0};
    end else if (state == S_READ) begin
      br_req <= '{cmd: burst_ram_pkg::BR_READ, addr: fill_addr,
                  wr_data: data_mem[idx], data_mask: '0};
    end
  end

endmodule

//--- logic/load_align.sv
`timescale 1ns/1ps
`include "ramio_settings.svh"

module load_align (
  input  logic                       clk,
  input  logic                       reset,
  input  burst_ram_pkg::load_rsp_t   rsp,
  input  logic                       rsp_valid,
  output logic [`CPU_DATA_BITS-1:0]  data_out,
  output logic                       data_out_ready
);

  logic [`BR_DATA_BITS-1:0] shifted;
  logic [`CPU_DATA_BITS-1:0] value;

  assign shifted = rsp.data >> {rsp.offset, 3'b000};  // addressed byte to bit 0

  always_comb begin
    case (rsp.read_type)
      cpu_bus_pkg::RD_BYTE:   value = {{24{shifted[7]}}, shifted[7:0]};
      cpu_bus_pkg::RD_HALF:   value = {{16{shifted[15]}}, shifted[15:0]};
      cpu_bus_pkg::RD_WORD:   value = shifted[31:0];
      cpu_bus_pkg::RD_BYTE_U: value = {24'b0, shifted[7:0]};
      cpu_bus_pkg::RD_HALF_U: value = {16'b0, shifted[15:0]};
      default:                value = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      data_out_ready <= 1'b0;
    end else begin
      data_out_ready <= rsp_valid;  // one pulse per read
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_valid) begin
      data_out <= value;
    end
  end

endmodule

//--- logic/ramio.sv
`timescale 1ns/1ps
`include "ramio_settings.svh"

module ramio (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          init_calib,
  input  logic                          enable,
  input  cpu_bus_pkg::write_type_t      write_type,
  input  cpu_bus_pkg::read_type_t       read_type,
  input  logic [`CPU_ADDR_BITS-1:0]     address,
  input  logic [`CPU_DATA_BITS-1:0]     data_in,
  input  burst_ram_pkg::line_t          br_rd_data,
  input  logic                          br_rd_data_valid,
  output logic                          busy,
  output logic [`CPU_DATA_BITS-1:0]     data_out,
  output logic                          data_out_ready,
  output logic                          br_cmd,        // 0 read, 1 write
  output logic                          br_cmd_en,
  output logic [`RAM_ADDR_BITS-1:0]     br_addr,
  output burst_ram_pkg::line_t          br_wr_data,
  output logic [`BR_DATA_BITS/8-1:0]    br_data_mask
);

  cpu_bus_pkg::mem_op_t op;
  logic op_valid;
  logic op_ready;
  burst_ram_pkg::br_cmd_t br_req;
  burst_ram_pkg::load_rsp_t rsp;
  logic rsp_valid;

  // ---------------------------------------------------------------------------
  // decode, cache, align
  // ---------------------------------------------------------------------------
  access_decode u_decode (
    .clk, .reset, .enable, .write_type, .read_type, .address, .data_in,
    .op_ready, .busy, .op, .op_valid
  );

  line_cache u_cache (
    .clk, .reset, .op, .op_valid, .op_ready, .init_calib,
    .br_req, .br_cmd_en, .br_rd_data, .br_rd_data_valid,
    .rsp, .rsp_valid
  );

  load_align u_align (
    .clk, .reset, .rsp, .rsp_valid, .data_out, .data_out_ready
  );

  // burst command fields out to the controller
  assign br_cmd = br_req.cmd;
  assign br_addr = br_req.addr;
  assign br_wr_data = br_req.wr_data;
  assign br_data_mask = br_req.data_mask;

endmodule

//--- logic/ramio_settings.svh
`ifndef RAMIO_SETTINGS_SVH
`define RAMIO_SETTINGS_SVH

`define CPU_ADDR_BITS 32
`define CPU_DATA_BITS 32
`define RAM_ADDR_BITS 21                        // burst byte address
`define LINE_ADDR_BITS (`RAM_ADDR_BITS - 3)     // 8 bytes per line
`define LINE_INDEX_BITS 4                       // 16 cache lines
`define BR_DATA_BITS 64
`define BR_WRITE_GAP 4                          // idle cycles after a write command

`endif

//--- src.f
+incdir+logic
logic/cpu_bus_pkg.sv
logic/burst_ram_pkg.sv
logic/access_decode.sv
logic/line_cache.sv
logic/load_align.sv
logic/ramio.sv
tests/burst_ram_sim.sv
tests/ramio_tb.sv

//--- tests/burst_ram_sim.sv
`timescale 1ns/1ps
`include "ramio_settings.svh"

module burst_ram_sim (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         br_cmd,        // 0 read, 1 write
  input  logic                         br_cmd_en,
  input  logic [`RAM_ADDR_BITS-1:0]    br_addr,
  input  logic [`BR_DATA_BITS-1:0]     br_wr_data,
  input  logic [`BR_DATA_BITS/8-1:0]   br_data_mask,
  output logic [`BR_DATA_BITS-1:0]     br_rd_data,
  output logic                         br_rd_data_valid
);

  logic [7:0] store [int unsigned];  // only bytes written so far
  integer lat_seed = 88;
  int wait_cnt;
  logic pending;
  logic [`RAM_ADDR_BITS-1:0] rd_addr;

  // power-up contents, a mix of every address bit
  function automatic logic [7:0] fill_byte(input int unsigned a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'ha5;
  endfunction

  function automatic logic [7:0] stored_byte(input int unsigned a);
    if (store.exists(a)) begin
      return store[a];
    end
    return fill_byte(a);
  endfunction

  always @(posedge clk) begin
    logic [`BR_DATA_BITS-1:0] line;
    if (reset) begin
      pending <= 1'b0;
      wait_cnt <= 0;
      br_rd_data_valid <= 1'b0;
    end else begin
      br_rd_data_valid <= 1'b0;
      if (br_cmd_en && br_cmd) begin
        for (int i = 0; i < `BR_DATA_BITS / 8; i++) begin
          if (!br_data_mask[i]) begin
            store[br_addr + i] = br_wr_data[i*8 +: 8];  // mask bit 0 writes
          end
        end
      end else if (br_cmd_en) begin
        pending <= 1'b1;
        rd_addr <= br_addr;
        wait_cnt <= ($random(lat_seed) & 15) + 1;  // 1 to 16 cycles
      end
      if (pending) begin
        if (wait_cnt <= 1) begin
          for (int i = 0; i < `BR_DATA_BITS / 8; i++) begin
            line[i*8 +: 8] = stored_byte(rd_addr + i);
          end
          br_rd_data <= line;
          br_rd_data_valid <= 1'b1;
          pending <= 1'b0;
        end else begin
          wait_cnt <= wait_cnt - 1;
        end
      end
    end
  end

endmodule

//--- tests/ramio_tb.sv
`timescale 1ns/1ps
`include "ramio_settings.svh"

module ramio_tb;

  localparam int HALF = 4;
  localparam int PERIOD = 2 * HALF;
  localparam int ADDR_BITS = `RAM_ADDR_BITS;
  localparam int unsigned ADDR_MASK = (1 << ADDR_BITS) - 1;
  localparam int LINES = 1 << `LINE_INDEX_BITS;
  localparam int WORD_PAIRS = 32;
  localparam int MIX_COUNT = 200;
  localparam int LATENCY_RUNS = 4;
  // calib 2, round trip, extension 38, conflict 36, mixed, latency
  localparam int REQUESTS = 2 + 2 * WORD_PAIRS + 38 + 36 + MIX_COUNT + 2 * LATENCY_RUNS;
  localparam int CYCLE_LIMIT = 40 * REQUESTS;

  logic clk;
  logic reset;
  logic init_calib;
  logic enable;
  cpu_bus_pkg::write_type_t write_type;
  cpu_bus_pkg::read_type_t read_type;
  logic [31:0] address;
  logic [31:0] data_in;
  logic busy;
  logic [31:0] data_out;
  logic data_out_ready;
  logic br_cmd;
  logic br_cmd_en;
  logic [ADDR_BITS-1:0] br_addr;
  burst_ram_pkg::line_t br_wr_data;
  burst_ram_pkg::line_t br_rd_data;
  logic [`BR_DATA_BITS/8-1:0] br_data_mask;
  logic br_rd_data_valid;

  logic [7:0] model [int unsigned];  // bytes written by the CPU side
  logic [31:0] exp_q [$];            // read results still to come
  integer seed;
  int cycles = 0;
  time accept_time;

  ramio u_dut (
    .clk, .reset, .init_calib, .enable, .write_type, .read_type, .address, .data_in,
    .br_rd_data, .br_rd_data_valid, .busy, .data_out, .data_out_ready,
    .br_cmd, .br_cmd_en, .br_addr, .br_wr_data, .br_data_mask
  );

  burst_ram_sim u_ram (
    .clk, .reset, .br_cmd, .br_cmd_en, .br_addr, .br_wr_data, .br_data_mask,
    .br_rd_data, .br_rd_data_valid
  );

  always #HALF clk = ~clk;

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------
  function automatic logic [7:0] initial_byte(input int unsigned a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'ha5;
  endfunction

  function automatic logic [7:0] model_byte(input int unsigned a);
    if (model.exists(a)) begin
      return model[a];
    end
    return initial_byte(a);
  endfunction

  function automatic logic [31:0] expected_load(input int unsigned a,
                                                input cpu_bus_pkg::read_type_t rt);
    logic [31:0] raw;
    raw = {model_byte(a + 3), model_byte(a + 2), model_byte(a + 1), model_byte(a)};
    case (rt)
      cpu_bus_pkg::RD_BYTE:   return {{24{raw[7]}}, raw[7:0]};
      cpu_bus_pkg::RD_HALF:   return {{16{raw[15]}}, raw[15:0]};
      cpu_bus_pkg::RD_BYTE_U: return {24'h0, raw[7:0]};
      cpu_bus_pkg::RD_HALF_U: return {16'h0, raw[15:0]};
      default:                return raw;
    endcase
  endfunction

  function automatic int unsigned rand_addr(input int unsigned align);
    int unsigned r;
    r = $random(seed);
    return r & ADDR_MASK & ~(align - 1);
  endfunction

  function automatic int unsigned line_base(input int unsigned tag, input int unsigned idx);
    return (((tag << `LINE_INDEX_BITS) | idx) << 3) & ADDR_MASK;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, want);
      $display("Test failures found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // --------------------------------------------------------------------------
  // request driver for the falling edge
  // --------------------------------------------------------------------------
  task automatic issue_request(input cpu_bus_pkg::write_type_t wt,
                               input cpu_bus_pkg::read_type_t rt,
                               input int unsigned a, input logic [31:0] d);
    int n;
    while (busy) @(negedge clk);
    enable = 1'b1;
    write_type = wt;
    read_type = rt;
    address = a;
    data_in = d;
    accept_time = $time + HALF;  // next rising edge takes it
    case (wt)
      cpu_bus_pkg::WR_BYTE: n = 1;
      cpu_bus_pkg::WR_HALF: n = 2;
      cpu_bus_pkg::WR_WORD: n = 4;
      default:              n = 0;
    endcase
    for (int i = 0; i < n; i++) begin
      model[a + i] = d[i*8 +: 8];
    end
    if (wt == cpu_bus_pkg::WR_NONE) begin
      exp_q.push_back(expected_load(a, rt));
    end
    @(negedge clk);
    enable = 1'b0;
    write_type = cpu_bus_pkg::WR_NONE;
    read_type = cpu_bus_pkg::RD_NONE;
  endtask

  task automatic write_mem(input cpu_bus_pkg::write_type_t wt, input int unsigned a,
                           input logic [31:0] d);
    issue_request(wt, cpu_bus_pkg::RD_NONE, a, d);
  endtask

  task automatic read_mem(input cpu_bus_pkg::read_type_t rt, input int unsigned a);
    issue_request(cpu_bus_pkg::WR_NONE, rt, a, 32'h0);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  task automatic check_outputs_low();
    check("busy", busy, 0);
    check("data_out_ready", data_out_ready, 0);
    check("br_cmd_en", br_cmd_en, 0);
  endtask

  // responses checked in order before the edge updates them
  always @(posedge clk) begin
    if (!reset && data_out_ready) begin
      if (exp_q.size() == 0) begin
        $display("read response at %0t ns with no read outstanding", $time);
        $display("Test failures found");
        $fatal(1, "unexpected response");
      end else begin
        check("data_out", data_out, exp_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("run hung, still busy after %0d cycles", CYCLE_LIMIT);
      $display("Test failures found");
      $fatal(1, "timeout");
    end
  end

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------
  initial begin
    int unsigned a;
    int unsigned base;
    int unsigned off;
    int unsigned addrs [16];
    int unsigned tag0;
    int unsigned idx0;
    int sel;
    int lat;
    logic [31:0] d;

    seed = 88;
    clk = 1'b0;
    reset = 1'b1;
    init_calib = 1'b0;
    enable = 1'b0;
    write_type = cpu_bus_pkg::WR_NONE;
    read_type = cpu_bus_pkg::RD_NONE;
    address = '0;
    data_in = '0;

    repeat (8) begin
      @(negedge clk);
      check_outputs_low();
    end
    reset = 1'b0;
    repeat (2) begin
      @(negedge clk);
      check_outputs_low();
    end

    // no burst traffic until calibration is done
    a = rand_addr(4);
    write_mem(cpu_bus_pkg::WR_WORD, a, $random(seed));
    read_mem(cpu_bus_pkg::RD_WORD, a);
    repeat (30) begin
      @(negedge clk);
      check("br_cmd_en", br_cmd_en, 0);
      check("data_out_ready", data_out_ready, 0);
      check("busy", busy, 1);
    end
    init_calib = 1'b1;
    wait_drain();

    for (int i = 0; i < WORD_PAIRS; i++) begin
      addrs[i % 16] = rand_addr(4);
      write_mem(cpu_bus_pkg::WR_WORD, addrs[i % 16], $random(seed));
      if (i % 16 == 15) begin
        for (int j = 0; j < 16; j++) begin
          read_mem(cpu_bus_pkg::RD_WORD, addrs[j]);
        end
      end
    end
    wait_drain();

    // byte and half lanes with both sign bit values
    base = rand_addr(8);
    for (int o = 0; o < 8; o++) begin
      d = $random(seed);
      d[7] = o[0];
      write_mem(cpu_bus_pkg::WR_BYTE, base + o, d);
      read_mem(cpu_bus_pkg::RD_BYTE, base + o);
      read_mem(cpu_bus_pkg::RD_BYTE_U, base + o);
    end
    for (int o = 0; o < 8; o += 2) begin
      d = $random(seed);
      d[15] = o[1];
      write_mem(cpu_bus_pkg::WR_HALF, base + o, d);
      read_mem(cpu_bus_pkg::RD_HALF, base + o);
      read_mem(cpu_bus_pkg::RD_HALF_U, base + o);
    end
    read_mem(cpu_bus_pkg::RD_WORD, base);
    read_mem(cpu_bus_pkg::RD_WORD, base + 4);
    wait_drain();

    // four tags on each of four indices, then a fifth tag flushes them
    tag0 = $random(seed);
    idx0 = $random(seed);
    for (int k = 0; k < 16; k++) begin
      off = ($random(seed) & 1) * 4;
      addrs[k] = line_base(tag0 + k / 4, (idx0 + k % 4) % LINES) + off;
      write_mem(cpu_bus_pkg::WR_WORD, addrs[k], $random(seed));
    end
    for (int k = 0; k < 16; k++) begin
      read_mem(cpu_bus_pkg::RD_WORD, addrs[k]);
    end
    for (int j = 0; j < 4; j++) begin
      read_mem(cpu_bus_pkg::RD_WORD, line_base(tag0 + 4, (idx0 + j) % LINES));
    end
    wait_drain();
    for (int k = 0; k < 16; k++) begin
      for (int b = 0; b < 4; b++) begin
        check("burst store byte", u_ram.stored_byte(addrs[k] + b), model_byte(addrs[k] + b));
      end
    end

    // mixed traffic in a 512-byte window
    base = rand_addr(512);
    for (int n = 0; n < MIX_COUNT; n++) begin
      sel = $random(seed) & 7;
      off = $random(seed) & 511;
      d = $random(seed);
      case (sel)
        0: write_mem(cpu_bus_pkg::WR_BYTE, base + off, d);
        1: write_mem(cpu_bus_pkg::WR_HALF, base + (off & ~32'd1), d);
        2: write_mem(cpu_bus_pkg::WR_WORD, base + (off & ~32'd3), d);
        3: read_mem(cpu_bus_pkg::RD_BYTE, base + off);
        4: read_mem(cpu_bus_pkg::RD_BYTE_U, base + off);
        5: read_mem(cpu_bus_pkg::RD_HALF, base + (off & ~32'd1));
        6: read_mem(cpu_bus_pkg::RD_HALF_U, base + (off & ~32'd1));
        default: read_mem(cpu_bus_pkg::RD_WORD, base + (off & ~32'd3));
      endcase
    end
    wait_drain();

    for (int n = 0; n < LATENCY_RUNS; n++) begin
      a = rand_addr(4);
      read_mem(cpu_bus_pkg::RD_WORD, a);
      wait_drain();
      read_mem(cpu_bus_pkg::RD_WORD, a);  // line now present
      while (!data_out_ready) @(negedge clk);
      lat = int'(($time - HALF - accept_time) / PERIOD);
      check("hit latency cycles", lat, 3);
      wait_drain();
    end

    // quiet tail so a stray response still shows up
    repeat (10) @(negedge clk);
    $display("All tests passed!");
    $finish;
  end

endmodule
